// File: Makefile
# Verilator build and run for the execute stage testbench.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= exec_tb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# The run passes only when the log holds the pass line.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: all.f
rtl/exec_pkg.sv
rtl/exec_control.sv
rtl/exec_alu.sv
rtl/exec_data_mem.sv
rtl/exec_pipe_regs.sv
rtl/exec_top.sv
testbench/exec_asserts.sv
testbench/exec_tb.sv

// File: rtl/exec_alu.sv
/*
 * Execute stage ALU.
 * Operand muxes, immediate fields and the five operations, plus
 * zero and negative of the result.
 */
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  logic [exec_pkg::INSTR_W-1:0] i_instr,
    input  logic [exec_pkg::DATA_W-1:0]  i_r1_data,
    input  logic [exec_pkg::DATA_W-1:0]  i_r2_data,
    input  logic [exec_pkg::DATA_W-1:0]  i_pc3,
    input  logic [exec_pkg::DATA_W-1:0]  i_alu_out,
    input  exec_pkg::alu1_sel_e          i_alu1_sel,
    input  exec_pkg::alu2_sel_e          i_alu2_sel,
    input  exec_pkg::alu_op_e            i_alu_op,
    output logic [exec_pkg::DATA_W-1:0]  o_result,
    output logic                         o_zero,
    output logic                         o_neg
);
    import exec_pkg::*;

    logic [DATA_W-1:0] imm4;
    logic [DATA_W-1:0] imm5;
    logic [DATA_W-1:0] imm3;
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic              sh_right;
    logic [1:0]        sh_amt;

    // Immediates.
    assign imm4 = {{(DATA_W-4){i_instr[7]}}, i_instr[7:4]};    // Sign-extended.
    assign imm5 = {{(DATA_W-5){1'b0}}, i_instr[7:3]};
    assign imm3 = {{(DATA_W-3){1'b0}}, i_instr[7:5]};

    always_comb begin
        case (i_alu1_sel)
            A1_PC3:    op_a = i_pc3;
            A1_ALUOUT: op_a = i_alu_out;
            default:   op_a = i_r1_data;
        endcase
    end

    always_comb begin
        case (i_alu2_sel)
            A2_ALUOUT: op_b = i_alu_out;
            A2_IMM4:   op_b = imm4;
            A2_IMM5:   op_b = imm5;
            A2_IMM3:   op_b = imm3;
            default:   op_b = i_r2_data;
        endcase
    end

    // Shift control comes from IMM3 through operand B.
    assign sh_right = op_b[2];              // 1 means right.
    assign sh_amt   = op_b[1:0];

    always_comb begin
        case (i_alu_op)
            ALU_SUB:   o_result = op_a - op_b;
            ALU_OR:    o_result = op_a | op_b;
            ALU_NAND:  o_result = ~(op_a & op_b);
            ALU_SHIFT: o_result = sh_right ? (op_a >> sh_amt) : (op_a << sh_amt);
            default:   o_result = op_a + op_b;
        endcase
    end

    assign o_zero = (o_result == '0);
    assign o_neg  = o_result[DATA_W-1];

endmodule

`default_nettype wire

// File: rtl/exec_control.sv
/*
 * Execute stage control.
 * Decodes the opcode into datapath strobes and mux selects, swapping
 * register operands for ALUout when the bypass flags are set.
 */
`timescale 1ns/1ps
`default_nettype none

module exec_control (
    input  exec_pkg::opcode_e   i_opcode,
    input  logic                i_en_exec,
    input  logic                i_bypass_alu1,
    input  logic                i_bypass_alu2,
    output logic                o_ir3_load,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output logic                o_mdr_load,
    output logic                o_flag_write,
    output logic                o_alu_out_write,
    output exec_pkg::alu1_sel_e o_alu1_sel,
    output exec_pkg::alu2_sel_e o_alu2_sel,
    output exec_pkg::alu_op_e   o_alu_op,
    output logic                o_reg_in
);
    import exec_pkg::*;

    alu1_sel_e reg_a1;                      // Register operand A, maybe forwarded.
    alu2_sel_e reg_a2;                      // Register operand B, maybe forwarded.
    logic      is_shift;
    logic      is_ori;

    assign reg_a1   = i_bypass_alu1 ? A1_ALUOUT : A1_R1;
    assign reg_a2   = i_bypass_alu2 ? A2_ALUOUT : A2_R2;
    assign is_shift = (i_opcode[2:0] == 3'(OP_SHIFT));
    assign is_ori   = (i_opcode[2:0] == 3'(OP_ORI));

    always_comb begin
        // Bubble values.
        o_ir3_load      = 1'b0;
        o_mem_read      = 1'b0;
        o_mem_write     = 1'b0;
        o_mdr_load      = 1'b0;
        o_flag_write    = 1'b0;
        o_alu_out_write = 1'b0;
        o_alu1_sel      = A1_R1;
        o_alu2_sel      = A2_R2;
        o_alu_op        = ALU_ADD;
        o_reg_in        = 1'b0;
        if (i_en_exec) begin
            o_ir3_load = 1'b1;              // Everything but stop loads IR3.
            o_alu_op   = ALU_OR;
            if (is_shift) begin
                o_alu1_sel      = reg_a1;
                o_alu2_sel      = A2_IMM3;
                o_alu_op        = ALU_SHIFT;
                o_alu_out_write = 1'b1;
                o_flag_write    = 1'b1;
            end else if (is_ori) begin
                o_alu1_sel      = reg_a1;
                o_alu2_sel      = A2_IMM5;
                o_alu_out_write = 1'b1;
                o_flag_write    = 1'b1;
            end else begin
                case (i_opcode)
                    OP_ADD, OP_SUB, OP_NAND: begin
                        o_alu1_sel      = reg_a1;
                        o_alu2_sel      = reg_a2;
                        o_alu_out_write = 1'b1;
                        o_flag_write    = 1'b1;
                        if (i_opcode == OP_ADD) o_alu_op = ALU_ADD;
                        else if (i_opcode == OP_SUB) o_alu_op = ALU_SUB;
                        else o_alu_op = ALU_NAND;
                    end
                    OP_LOAD: begin
                        o_alu1_sel      = reg_a1;
                        o_alu2_sel      = reg_a2;
                        o_mem_read      = 1'b1;
                        o_mdr_load      = 1'b1;
                        o_alu_out_write = 1'b1;
                        o_reg_in        = 1'b1;     // Write back from MDR.
                    end
                    OP_STORE: begin
                        o_alu1_sel  = reg_a1;
                        o_alu2_sel  = reg_a2;
                        o_mem_write = 1'b1;
                    end
                    OP_NOP, OP_BZ, OP_BNZ, OP_BPZ: begin
                        // Branch target is PC3 plus IMM4.
                        o_alu1_sel = A1_PC3;
                        o_alu2_sel = A2_IMM4;
                        o_alu_op   = ALU_ADD;
                    end
                    OP_STOP: o_ir3_load = 1'b0;    // Freeze IR3.
                    default: ;                      // Unused codes only load IR3.
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/exec_data_mem.sv
/*
 * Data memory, 256 x 8.
 * Combinational read, write on the rising clock edge.
 */
`timescale 1ns/1ps
`default_nettype none

module exec_data_mem (
    input  logic                        i_clk,
    input  logic [exec_pkg::MEM_AW-1:0] i_addr,
    input  logic [exec_pkg::DATA_W-1:0] i_wdata,
    input  logic                        i_write,
    input  logic                        i_read,
    output logic [exec_pkg::DATA_W-1:0] o_rdata
);
    import exec_pkg::*;

    localparam int DEPTH = 2 ** MEM_AW;

    logic [DATA_W-1:0] mem [0:DEPTH-1];

    // ########################################
    // Write port
    // ########################################
    always_ff @(posedge i_clk) begin
        if (i_write) begin
            mem[i_addr] <= i_wdata;
        end
    end

    // ########################################
    // Read port
    // ########################################
    // Reads as zero unless a load is active.
    assign o_rdata = i_read ? mem[i_addr] : '0;

endmodule

`default_nettype wire

// File: rtl/exec_pipe_regs.sv
/*
 * Stage-3 pipeline registers.
 * Holds IR3, ALUout, target, flags, MDR and forward-valid, and compares
 * IR3's destination with the current sources for bypass.
 */
`timescale 1ns/1ps
`default_nettype none

module exec_pipe_regs (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic [exec_pkg::INSTR_W-1:0] i_instr,
    input  logic                         i_ir3_load,
    input  logic                         i_alu_out_write,
    input  logic                         i_flag_write,
    input  logic                         i_mdr_load,
    input  logic                         i_reg_in,
    input  logic [exec_pkg::DATA_W-1:0]  i_result,
    input  logic                         i_zero,
    input  logic                         i_neg,
    input  logic [exec_pkg::DATA_W-1:0]  i_rdata,
    output logic [exec_pkg::INSTR_W-1:0] o_ir3,
    output logic [exec_pkg::DATA_W-1:0]  o_alu_out,
    output logic [exec_pkg::DATA_W-1:0]  o_target,
    output logic                         o_flag_z,
    output logic                         o_flag_n,
    output logic [exec_pkg::DATA_W-1:0]  o_mdr,
    output logic                         o_reg_in,
    output logic                         o_bypass_alu1,
    output logic                         o_bypass_alu2
);
    import exec_pkg::*;

    logic fwd_valid;                        // IR3's result sits in ALUout.

    // ########################################
    // Stage-3 state
    // ########################################
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ir3     <= '0;
            o_target  <= '0;
            o_alu_out <= '0;
            o_flag_z  <= 1'b0;
            o_flag_n  <= 1'b0;
            o_mdr     <= '0;
            o_reg_in  <= 1'b0;
            fwd_valid <= 1'b0;
        end else begin
            if (i_ir3_load) begin
                o_ir3    <= i_instr;
                o_target <= i_result;
            end
            if (i_alu_out_write) begin
                o_alu_out <= i_result;
            end
            if (i_flag_write) begin
                o_flag_z <= i_zero;
                o_flag_n <= i_neg;
            end
            if (i_mdr_load) begin
                o_mdr <= i_rdata;
            end
            o_reg_in  <= i_reg_in;
            // Loads write ALUout too, but their value is not forwardable.
            fwd_valid <= i_alu_out_write & ~i_reg_in;
        end
    end

    // ########################################
    // Bypass compare
    // ########################################
    // IR3 destination is R1 (bits 5:4); sources are bits 5:4 and 7:6.
    assign o_bypass_alu1 = fwd_valid && (o_ir3[5:4] == i_instr[5:4]);
    assign o_bypass_alu2 = fwd_valid && (o_ir3[5:4] == i_instr[7:6]);

endmodule

`default_nettype wire

// File: rtl/exec_pkg.sv
/*
 * Execute stage shared definitions.
 * Widths, opcodes, ALU operations and operand mux selects.
 */
`default_nettype none

package exec_pkg;

    // ########################################
    // Widths
    // ########################################
    localparam int DATA_W  = 8;             // Datapath width.
    localparam int MEM_AW  = 8;             // Data memory address width.
    localparam int INSTR_W = 8;             // Instruction width.

    // ########################################
    // Encodings
    // ########################################
    // Instruction classes, matched on instr[3:0].
    // SHIFT and ORI only look at instr[2:0].
    typedef enum logic [3:0] {
        OP_LOAD  = 4'd0,
        OP_STOP  = 4'd1,
        OP_STORE = 4'd2,
        OP_SHIFT = 4'd3,
        OP_ADD   = 4'd4,
        OP_BZ    = 4'd5,
        OP_SUB   = 4'd6,
        OP_ORI   = 4'd7,
        OP_NAND  = 4'd8,
        OP_BNZ   = 4'd9,
        OP_NOP   = 4'd10,
        OP_BPZ   = 4'd13
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_OR    = 3'd2,
        ALU_NAND  = 3'd3,
        ALU_SHIFT = 3'd4
    } alu_op_e;

    typedef enum logic [1:0] {A1_PC3 = 2'd0, A1_R1 = 2'd1, A1_ALUOUT = 2'd2} alu1_sel_e;

    typedef enum logic [2:0] {
        A2_R2 = 3'd0, A2_ALUOUT = 3'd1, A2_IMM4 = 3'd2, A2_IMM5 = 3'd3, A2_IMM3 = 3'd4
    } alu2_sel_e;

endpackage

`default_nettype wire

// File: rtl/exec_top.sv
/*
 * Execute stage top level.
 * Connects control, ALU, data memory and stage-3 registers.
 */
`timescale 1ns/1ps
`default_nettype none

module exec_top (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_en_exec,
    input  logic [exec_pkg::INSTR_W-1:0] i_instr,
    input  logic [exec_pkg::DATA_W-1:0]  i_r1_data,
    input  logic [exec_pkg::DATA_W-1:0]  i_r2_data,
    input  logic [exec_pkg::DATA_W-1:0]  i_pc3,
    output logic [exec_pkg::INSTR_W-1:0] o_ir3,
    output logic [exec_pkg::DATA_W-1:0]  o_alu_out,
    output logic [exec_pkg::DATA_W-1:0]  o_target,
    output logic                         o_flag_z,
    output logic                         o_flag_n,
    output logic [exec_pkg::DATA_W-1:0]  o_mdr,
    output logic                         o_reg_in
);
    import exec_pkg::*;

    // Control strobes and selects.
    logic      ir3_load, mem_read, mem_write, mdr_load;
    logic      flag_write, alu_out_write, reg_in;
    alu1_sel_e alu1_sel;
    alu2_sel_e alu2_sel;
    alu_op_e   alu_op;
    logic      bypass_alu1, bypass_alu2;

    // Datapath.
    logic [DATA_W-1:0] result, rdata;
    logic              zero, neg;

    exec_control u_control (
        .i_opcode        (opcode_e'(i_instr[3:0])),
        .i_en_exec       (i_en_exec),
        .i_bypass_alu1   (bypass_alu1),
        .i_bypass_alu2   (bypass_alu2),
        .o_ir3_load      (ir3_load),
        .o_mem_read      (mem_read),
        .o_mem_write     (mem_write),
        .o_mdr_load      (mdr_load),
        .o_flag_write    (flag_write),
        .o_alu_out_write (alu_out_write),
        .o_alu1_sel      (alu1_sel),
        .o_alu2_sel      (alu2_sel),
        .o_alu_op        (alu_op),
        .o_reg_in        (reg_in)
    );

    exec_alu u_alu (
        .i_instr (i_instr), .i_r1_data (i_r1_data), .i_r2_data (i_r2_data),
        .i_pc3 (i_pc3), .i_alu_out (o_alu_out),
        .i_alu1_sel (alu1_sel), .i_alu2_sel (alu2_sel), .i_alu_op (alu_op),
        .o_result (result), .o_zero (zero), .o_neg (neg)
    );

    // Address is the ALU result, store data is R1.
    exec_data_mem u_data_mem (
        .i_clk (i_clk), .i_addr (result[MEM_AW-1:0]), .i_wdata (i_r1_data),
        .i_write (mem_write), .i_read (mem_read), .o_rdata (rdata)
    );

    exec_pipe_regs u_pipe_regs (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_instr (i_instr),
        .i_ir3_load (ir3_load), .i_alu_out_write (alu_out_write),
        .i_flag_write (flag_write), .i_mdr_load (mdr_load), .i_reg_in (reg_in),
        .i_result (result), .i_zero (zero), .i_neg (neg), .i_rdata (rdata),
        .o_ir3 (o_ir3), .o_alu_out (o_alu_out), .o_target (o_target),
        .o_flag_z (o_flag_z), .o_flag_n (o_flag_n), .o_mdr (o_mdr),
        .o_reg_in (o_reg_in), .o_bypass_alu1 (bypass_alu1),
        .o_bypass_alu2 (bypass_alu2)
    );

endmodule

`default_nettype wire

// File: testbench/exec_asserts.sv
/*
 * Execute stage assertions.
 * Hold rules for IR3 and the flags, and the write-back source check.
 */
`timescale 1ns/1ps
`default_nettype none

module exec_asserts (
    input  logic                         i_clk,
    input  logic                         i_rst_n,
    input  logic                         i_en_exec,
    input  logic [exec_pkg::INSTR_W-1:0] i_instr,
    input  logic [exec_pkg::INSTR_W-1:0] o_ir3,
    input  logic                         o_flag_z,
    input  logic                         o_flag_n,
    input  logic                         o_reg_in,
    input  logic                         i_mdr_load
);
    import exec_pkg::*;

    logic [3:0] opcode;
    logic       no_flag_op;                 // Opcodes that leave the flags alone.

    assign opcode     = i_instr[3:0];
    assign no_flag_op = opcode inside {OP_LOAD, OP_STORE, OP_STOP, OP_NOP,
                                       OP_BZ, OP_BNZ, OP_BPZ};

    // ########################################
    // Properties
    // ########################################
    ir3_holds_on_bubble: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_en_exec |=> $stable(o_ir3))
        else $error("IR3 changed after a bubble cycle");

    flags_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        no_flag_op |=> $stable({o_flag_z, o_flag_n}))
        else $error("Flags changed after a non-ALU opcode");

    // Write-back from MDR only follows an enabled load that filled MDR.
    reg_in_needs_mdr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_reg_in |-> $past(i_mdr_load && i_en_exec && opcode == OP_LOAD))
        else $error("Write-back selects MDR without a load");

endmodule

bind exec_top exec_asserts u_asserts (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_en_exec  (i_en_exec),
    .i_instr    (i_instr),
    .o_ir3      (o_ir3),
    .o_flag_z   (o_flag_z),
    .o_flag_n   (o_flag_n),
    .o_reg_in   (o_reg_in),
    .i_mdr_load (mdr_load)
);

`default_nettype wire

// File: testbench/exec_tb.sv
/*
 * Execute stage testbench.
 * Seeded random instruction stream checked against a stage-3 model.
 */
`timescale 1ns/1ps
`default_nettype none

module exec_tb;
    import exec_pkg::*;

    localparam int          CLK_PERIOD   = 10;
    localparam int          RESET_CYCLES = 16;
    localparam int          NUM_OPS      = 2000;
    localparam int          WATCHDOG_NS  = (RESET_CYCLES + NUM_OPS + 50) * CLK_PERIOD;
    localparam logic [31:0] SEED         = 32'hf316ed5a;

    logic               i_clk;
    logic               i_rst_n;
    logic               i_en_exec;
    logic [INSTR_W-1:0] i_instr;
    logic [DATA_W-1:0]  i_r1_data;
    logic [DATA_W-1:0]  i_r2_data;
    logic [DATA_W-1:0]  i_pc3;
    logic [INSTR_W-1:0] o_ir3;
    logic [DATA_W-1:0]  o_alu_out;
    logic [DATA_W-1:0]  o_target;
    logic               o_flag_z;
    logic               o_flag_n;
    logic [DATA_W-1:0]  o_mdr;
    logic               o_reg_in;

    // ########################################
    // Reference model state
    // ########################################
    logic [INSTR_W-1:0] ir3_m;
    logic [DATA_W-1:0]  alu_out_m;
    logic [DATA_W-1:0]  target_m;
    logic [DATA_W-1:0]  mdr_m;
    logic               flag_z_m;
    logic               flag_n_m;
    logic               reg_in_m;
    logic               fwd_m;
    logic               mdr_known;          // Low after a load from an unwritten byte.
    logic               target_known;       // Low after an unused code loads the target.
    logic [DATA_W-1:0]  mem_img [0:255];
    logic               mem_wr [0:255];
    string              cur_test;
    int                 n_fwd;
    int                 n_mem_hits;

    exec_top dut_i (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_en_exec (i_en_exec),
        .i_instr (i_instr), .i_r1_data (i_r1_data), .i_r2_data (i_r2_data),
        .i_pc3 (i_pc3), .o_ir3 (o_ir3), .o_alu_out (o_alu_out),
        .o_target (o_target), .o_flag_z (o_flag_z), .o_flag_n (o_flag_n),
        .o_mdr (o_mdr), .o_reg_in (o_reg_in)
    );

    initial i_clk = 1'b0;
    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // Logical shift one bit at a time, bit 2 of IMM3 picks right.
    function automatic logic [7:0] shift_ref(input logic [7:0] a, input logic [2:0] imm3);
        logic [7:0] v;
        v = a;
        for (int k = 0; k < int'(imm3[1:0]); k++) begin
            v = imm3[2] ? {1'b0, v[7:1]} : {v[6:0], 1'b0};
        end
        return v;
    endfunction

    function automatic string test_name(input logic en, input logic [3:0] op,
                                        input logic fwd);
        if (!en || op == OP_STOP) return "hold";
        if (op == 4'd12 || op == 4'd14) return "unused";
        if (op == OP_LOAD || op == OP_STORE) return "memory";
        if (op == OP_NOP || op == OP_BZ || op == OP_BNZ || op == OP_BPZ) return "branch_target";
        if (fwd) return "forwarding";
        return "arith_logic";
    endfunction

    task automatic check_val(input string test, input string sig,
                             input logic [7:0] exp, input logic [7:0] act);
        assert (act === exp) else begin
            $display("** Error [%s] %s: expected %02h, actual %02h", test, sig, exp, act);
            $display("TB FAILED");
            $fatal(1, "Output mismatch on %s", sig);
        end
    endtask

    task automatic check_outputs(input string test);
        check_val(test, "o_ir3", ir3_m, o_ir3);
        check_val(test, "o_alu_out", alu_out_m, o_alu_out);
        if (target_known) check_val(test, "o_target", target_m, o_target);
        check_val(test, "o_flag_z", {7'd0, flag_z_m}, {7'd0, o_flag_z});
        check_val(test, "o_flag_n", {7'd0, flag_n_m}, {7'd0, o_flag_n});
        check_val(test, "o_reg_in", {7'd0, reg_in_m}, {7'd0, o_reg_in});
        if (mdr_known) check_val(test, "o_mdr", mdr_m, o_mdr);
    endtask

    // Half of the register fields repeat IR3's destination to exercise bypass.
    task automatic drive_random();
        logic [1:0] f1;
        logic [1:0] f2;
        logic [7:0] mask;
        f1   = ($urandom() % 2 == 0) ? ir3_m[5:4] : 2'($urandom());
        f2   = ($urandom() % 2 == 0) ? ir3_m[5:4] : 2'($urandom());
        mask = ($urandom() % 2 == 0) ? 8'h0f : 8'hff;   // Small values reuse addresses.
        i_instr   = {f2, f1, 4'($urandom())};
        i_en_exec = (($urandom() % 100) < 85);
        i_r1_data = 8'($urandom()) & mask;
        i_r2_data = 8'($urandom()) & mask;
        i_pc3     = 8'($urandom());
    endtask

    // One edge of stage 3, from the inputs held during the cycle.
    task automatic model_step();
        logic [3:0]        op;
        logic              byp1;
        logic              byp2;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] res;
        logic              alu_wr;
        op       = i_instr[3:0];
        byp1     = fwd_m && (ir3_m[5:4] == i_instr[5:4]);
        byp2     = fwd_m && (ir3_m[5:4] == i_instr[7:6]);
        a        = byp1 ? alu_out_m : i_r1_data;
        b        = byp2 ? alu_out_m : i_r2_data;
        res      = '0;
        alu_wr   = 1'b0;
        cur_test = test_name(i_en_exec, op, byp1 || byp2);
        fwd_m    = 1'b0;
        reg_in_m = 1'b0;
        if (i_en_exec && op != OP_STOP) begin
            if (op[2:0] == 3'd3) begin
                res    = shift_ref(a, i_instr[7:5]);
                alu_wr = 1'b1;
            end else if (op[2:0] == 3'd7) begin
                res    = a | {3'b000, i_instr[7:3]};
                alu_wr = 1'b1;
            end else begin
                case (op)
                    OP_ADD: begin
                        res    = a + b;
                        alu_wr = 1'b1;
                    end
                    OP_SUB: begin
                        res    = a - b;
                        alu_wr = 1'b1;
                    end
                    OP_NAND: begin
                        res    = ~(a & b);
                        alu_wr = 1'b1;
                    end
                    OP_LOAD: begin
                        res       = a | b;          // Address also lands in ALUout.
                        alu_out_m = res;
                        reg_in_m  = 1'b1;
                        mdr_known = mem_wr[res];
                        mdr_m     = mem_img[res];
                        if (mem_wr[res]) n_mem_hits++;
                    end
                    OP_STORE: begin
                        res          = a | b;
                        mem_img[res] = i_r1_data;
                        mem_wr[res]  = 1'b1;
                    end
                    OP_NOP, OP_BZ, OP_BNZ, OP_BPZ: begin
                        res = i_pc3 + {{4{i_instr[7]}}, i_instr[7:4]};
                    end
                    default: ;
                endcase
            end
            if (alu_wr) begin
                alu_out_m = res;
                flag_z_m  = (res == 8'd0);
                flag_n_m  = res[7];
                fwd_m     = 1'b1;
                if (byp1 || byp2) n_fwd++;
            end
            ir3_m        = i_instr;
            target_m     = res;             // Target follows every IR3 load.
            target_known = (op != 4'd12) && (op != 4'd14);
        end
    endtask

    // ########################################
    // Watchdog
    // ########################################
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $fatal(1, "Watchdog expired");
    end

    // ########################################
    // Main sequence
    // ########################################
    initial begin
        void'($urandom(SEED));
        i_rst_n      = 1'b0;
        i_en_exec    = 1'b0;
        i_instr      = '0;
        i_r1_data    = '0;
        i_r2_data    = '0;
        i_pc3        = '0;
        n_fwd        = 0;
        n_mem_hits   = 0;
        ir3_m        = '0;
        alu_out_m    = '0;
        target_m     = '0;
        mdr_m        = '0;
        flag_z_m     = 1'b0;
        flag_n_m     = 1'b0;
        reg_in_m     = 1'b0;
        fwd_m        = 1'b0;
        mdr_known    = 1'b1;
        target_known = 1'b1;
        for (int k = 0; k < 256; k++) mem_wr[k] = 1'b0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        check_outputs("reset");
        for (int n = 0; n < NUM_OPS; n++) begin
            drive_random();
            @(posedge i_clk);
            #1;
            model_step();
            check_outputs(cur_test);
        end
        $display("Ops %0d, forwarded %0d, loads from written bytes %0d",
                 NUM_OPS, n_fwd, n_mem_hits);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
